// ==== design/fdc_pkg.sv ====
package fdc_pkg;

	// ====================
	// cpu register map
	localparam logic [1:0] A_COMMAND = 2'd0; // write side of address 0
	localparam logic [1:0] A_STATUS  = 2'd0; // read side of address 0
	localparam logic [1:0] A_TRACK   = 2'd1;
	localparam logic [1:0] A_SECTOR  = 2'd2;
	localparam logic [1:0] A_DATA    = 2'd3;

	// ====================
	// widths
	localparam int TRACK_W    = 8;
	localparam int SECTOR_W   = 8;
	localparam int OFFSET_W   = 20; // image byte offset, 1 MiB max
	localparam int BLK_IDX_W  = 2;  // block within a sector
	localparam int BLK_ADDR_W = 9;  // byte within a 512 byte block
	localparam int BUF_ADDR_W = 11;

	// command high nibble
	typedef enum logic [3:0] {
		OP_RESTORE,
		OP_SEEK,
		OP_STEP,
		OP_STEP_U,
		OP_STEP_IN,
		OP_STEP_IN_U,
		OP_STEP_OUT,
		OP_STEP_OUT_U,
		OP_READ,
		OP_READ_M,
		OP_WRITE,
		OP_WRITE_M,
		OP_READ_ADDR,
		OP_FORCE_INT,
		OP_READ_TRACK,
		OP_WRITE_TRACK
	} fdc_op_t;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_SEEK,
		ST_PRE_REQ,
		ST_PRE_WAIT,
		ST_RD_ARM,
		ST_RD_DELAY,
		ST_RD_XFER,
		ST_WR_ARM,
		ST_WR_DELAY,
		ST_WR_XFER,
		ST_FLUSH_CHK,
		ST_FLUSH_REQ,
		ST_FLUSH_WAIT,
		ST_ABORT,
		ST_BUSY_WAIT,
		ST_BUSY_DELAY,
		ST_END
	} fdc_state_t;

	// timing in ce ticks
	localparam int SEEK_DELAY     = 1023;
	localparam int DRQ_DELAY      = 15;
	localparam int WATCHDOG_TICKS = 4096;
	localparam int BUSY_TICKS     = 4000;

	// fixed track layouts by size_code
	// 26x128, 16x256, 9x512, 5x1024 and 10x512
	localparam logic [7:0] SECTORS_PER_TRACK [5] = '{8'd26, 8'd16, 8'd9, 8'd5, 8'd10};
	localparam logic [1:0] SECTOR_SIZE_CODE  [5] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd2};

endpackage

// ==== design/sector_buffer.sv ====
module sector_buffer import fdc_pkg::*; (
	input  logic                  clk_sys,
	input  logic [BUF_ADDR_W-1:0] addr_a,
	input  logic [7:0]            data_a,
	input  logic                  we_a,
	output logic [7:0]            q_a,
	input  logic [BUF_ADDR_W-1:0] addr_b,
	input  logic [7:0]            data_b,
	input  logic                  we_b,
	output logic [7:0]            q_b
);

	logic [7:0] mem [0:(1 << BUF_ADDR_W) - 1]; // room for a 1 KiB sector at any block offset

	// port a faces the sd device
	always @(posedge clk_sys) begin
		if (we_a) begin
			mem[addr_a] <= data_a;
			q_a <= data_a; // write-through
		end else begin
			q_a <= mem[addr_a];
		end
	end

	// port b faces the cpu
	always @(posedge clk_sys) begin
		if (we_b) begin
			mem[addr_b] <= data_b;
			q_b <= data_b;
		end else begin
			q_b <= mem[addr_b];
		end
	end

endmodule

// ==== design/disk_geometry.sv ====
module disk_geometry import fdc_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 img_mounted,
	input  logic [OFFSET_W-1:0]  img_size,
	input  logic                 layout,
	input  logic [2:0]           size_code,
	input  logic                 side,
	input  logic [TRACK_W-1:0]   head_track,
	input  logic [SECTOR_W-1:0]  sector,
	output logic [OFFSET_W-1:0]  img_offset,
	output logic [7:0]           spt,
	output logic [1:0]           sector_code,
	output logic [BLK_IDX_W-1:0] blk_count
);

	logic                 old_mounted;
	logic [OFFSET_W-1:0]  disk_size;
	logic                 layout_r;   // 1 = side-track-sector
	logic [2:0]           sc_idx;
	logic [7:0]           spt_c;
	logic [1:0]           code_c;
	logic [7:0]           dts;        // track and side folded into one index
	logic [15:0]          lin_idx;
	logic [OFFSET_W-1:0]  half_off;
	logic [OFFSET_W-1:0]  offs_c;
	logic [BLK_IDX_W-1:0] extra_c;

	// image parameters are taken when the mount strobe drops
	always_ff @(posedge clk_sys) begin
		old_mounted <= img_mounted;
		if (old_mounted && !img_mounted) begin
			disk_size <= img_size;
			layout_r  <= layout;
		end
	end

	always_comb begin
		sc_idx   = (size_code > 3'd4) ? 3'd0 : size_code; // unused codes fall back to layout 0
		spt_c    = SECTORS_PER_TRACK[sc_idx];
		code_c   = SECTOR_SIZE_CODE[sc_idx];
		// side 1 of a side-track-sector image lives in the upper half
		dts      = layout_r ? {1'b0, head_track[6:0]} : {head_track[6:0], side};
		half_off = (layout_r && side) ? (disk_size >> 1) : '0;
		lin_idx  = 16'(dts) * 16'(spt_c) + 16'(sector) - 16'd1;
		offs_c   = half_off + (OFFSET_W'(lin_idx) << (5'd7 + 5'(code_c)));
		// extra blocks touched by 512 and 1024 byte sectors
		case (code_c)
			2'd2:    extra_c = (offs_c[BLK_ADDR_W-1:0] != '0) ? 2'd1 : 2'd0;
			2'd3:    extra_c = (offs_c[BLK_ADDR_W-1:0] != '0) ? 2'd2 : 2'd1;
			default: extra_c = 2'd0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		img_offset  <= offs_c;
		spt         <= spt_c;
		sector_code <= code_c;
		blk_count   <= extra_c;
	end

endmodule

// ==== design/cpu_bus_sync.sv ====
module cpu_bus_sync import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ce,
	input  logic       io_en,
	input  logic       rd,
	input  logic       wr,
	input  logic [1:0] addr,
	output logic       wr_start,
	output logic [1:0] bus_addr,
	output logic       rd_end_status,
	output logic       rd_end_data,
	output logic       wr_end_data
);

	logic       rde;
	logic       wre;
	logic       old_rd;
	logic       old_wr;
	logic       rd_rise;
	logic       wr_rise;
	logic [1:0] cur_addr; // register of the access in progress

	assign rde     = rd & io_en;
	assign wre     = wr & io_en;
	assign rd_rise = ce & rde & ~old_rd;
	assign wr_rise = ce & wre & ~old_wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rd   <= 1'b0;
			old_wr   <= 1'b0;
			cur_addr <= A_STATUS;
		end else if (ce) begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= addr;
		end
	end

	assign wr_start      = wr_rise;
	assign bus_addr      = (rd_rise | wr_rise) ? addr : cur_addr;
	assign rd_end_status = ce & old_rd & ~rde & (cur_addr == A_STATUS);
	assign rd_end_data   = ce & old_rd & ~rde & (cur_addr == A_DATA);
	assign wr_end_data   = ce & old_wr & ~wre & (cur_addr == A_DATA);

endmodule

// ==== design/sd_block_xfer.sv ====
module sd_block_xfer import fdc_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  logic                 blk_start,
	input  logic                 blk_write,
	input  logic [BLK_IDX_W-1:0] blk_count,
	input  logic [OFFSET_W-1:0]  img_offset,
	input  logic                 sd_ack,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic [BLK_IDX_W-1:0] sd_block,
	output logic [31:0]          sd_lba,
	output logic                 blk_done
);

	logic [5:0]           ack_sr;   // sd_ack synchronizer
	logic [BLK_IDX_W-1:0] last_blk;
	logic                 write_r;
	logic                 issue;    // next block request pending
	logic                 wait_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_sr   <= '0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			sd_block <= '0;
			last_blk <= '0;
			write_r  <= 1'b0;
			issue    <= 1'b0;
			wait_ack <= 1'b0;
			blk_done <= 1'b0;
		end else if (ce) begin
			ack_sr   <= {ack_sr[4:0], sd_ack};
			blk_done <= 1'b0;
			if (ack_sr[5:4] == 2'b01) begin // device took the request
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (blk_start) begin
				sd_block <= '0;
				last_blk <= blk_count;
				write_r  <= blk_write;
				issue    <= 1'b1;
			end else if (issue) begin
				sd_rd    <= ~write_r;
				sd_wr    <= write_r;
				wait_ack <= 1'b1;
				issue    <= 1'b0;
			end else if (wait_ack && ack_sr[5:4] == 2'b10) begin
				wait_ack <= 1'b0;
				if (sd_block == last_blk) begin
					blk_done <= 1'b1;
				end else begin
					sd_block <= sd_block + 1'b1;
					issue    <= 1'b1;
				end
			end
		end
	end

	// block part of the offset plus the running block
	assign sd_lba = 32'(img_offset[OFFSET_W-1:BLK_ADDR_W]) + 32'(sd_block);

endmodule

// ==== design/fdc_controller.sv ====
module fdc_controller import fdc_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ce,
	input  logic [7:0]            din,
	input  logic                  wr_start,
	input  logic [1:0]            bus_addr,
	input  logic                  rd_end_status,
	input  logic                  rd_end_data,
	input  logic                  wr_end_data,
	input  logic                  wp,
	input  logic                  ready,
	input  logic [7:0]            spt,
	input  logic [1:0]            sector_code,
	input  logic [OFFSET_W-1:0]   img_offset,
	input  logic                  blk_done,
	output logic [TRACK_W-1:0]    head_track,
	output logic [SECTOR_W-1:0]   sector,
	output logic [TRACK_W-1:0]    track_reg,
	output logic [7:0]            data_reg,
	output logic [7:0]            status,
	output logic                  drq,
	output logic                  busy,
	output logic                  intrq,
	output logic                  xfer_read,
	output logic [BUF_ADDR_W-1:0] byte_addr,
	output logic                  buf_we,
	output logic                  blk_start,
	output logic                  blk_write
);

	fdc_state_t            state;
	fdc_op_t               op;
	logic                  step_dir;    // 1 = outward
	logic                  cmd_mode;    // status layout, 0 = type I
	logic                  wpe;
	logic                  head_loaded;
	logic                  seek_err;
	logic                  lost_data;
	logic                  wr_fault;
	logic                  multi;
	logic                  byte_seen;   // cpu finished with the current byte
	logic [11:0]           timer;
	logic [12:0]           wd_timer;
	logic [BUF_ADDR_W-1:0] data_len;    // bytes left in this sector
	logic [TRACK_W-1:0]    next_track;
	logic                  last_byte;
	logic                  bark;

	assign op         = fdc_op_t'(din[7:4]);
	assign next_track = (din[6] ? din[5] : step_dir) ? head_track - 1'b1 : head_track + 1'b1;
	assign bark       = (wd_timer == '0);
	assign last_byte  = (data_len == BUF_ADDR_W'(1));
	assign buf_we     = wr_start & (bus_addr == A_DATA) & (state == ST_WR_XFER);

	// index pulse is not modelled
	assign status = cmd_mode ?
		{~ready, wp & wpe, wr_fault, seek_err, 1'b0, lost_data, drq, busy} :
		{~ready, wp & wpe, head_loaded, seek_err, 1'b0, head_track == '0, 1'b0, busy};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= ST_IDLE;
			head_track  <= '0;
			track_reg   <= '0;
			sector      <= '0;
			data_reg    <= '0;
			step_dir    <= 1'b0;
			cmd_mode    <= 1'b1;
			wpe         <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			lost_data   <= 1'b0;
			wr_fault    <= 1'b0;
			multi       <= 1'b0;
			byte_seen   <= 1'b0;
			drq         <= 1'b0;
			busy        <= 1'b0;
			intrq       <= 1'b0;
			xfer_read   <= 1'b0;
			timer       <= '0;
			wd_timer    <= '0;
			data_len    <= '0;
			byte_addr   <= '0;
			blk_start   <= 1'b0;
			blk_write   <= 1'b0;
		end else if (ce) begin
			blk_start <= 1'b0;
			if (wd_timer != '0)
				wd_timer <= wd_timer - 1'b1;
			if (rd_end_status)
				intrq <= 1'b0;
			if (xfer_read ? rd_end_data : wr_end_data)
				byte_seen <= 1'b1;

			// ====================
			// command sequencing
			case (state)
				ST_IDLE: ;
				ST_SEEK: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= ST_END;
					end else if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (sector == '0 || sector > spt) begin
						seek_err <= 1'b1; // record not found
						state    <= ST_END;
					end else begin
						byte_addr <= BUF_ADDR_W'(img_offset[BLK_ADDR_W-1:0]);
						data_len  <= 11'd128 << sector_code;
						state     <= ST_PRE_REQ;
					end
				end
				// writes prefetch too, sectors may not fill a block
				ST_PRE_REQ: begin
					blk_start <= 1'b1;
					blk_write <= 1'b0;
					state     <= ST_PRE_WAIT;
				end
				ST_PRE_WAIT: if (blk_done) state <= xfer_read ? ST_RD_ARM : ST_WR_ARM;
				ST_RD_ARM, ST_WR_ARM: begin
					timer <= 12'(DRQ_DELAY);
					state <= (state == ST_RD_ARM) ? ST_RD_DELAY : ST_WR_DELAY;
				end
				ST_RD_DELAY, ST_WR_DELAY: begin
					if (timer != '0) begin
						timer <= timer - 1'b1;
					end else begin
						byte_seen <= 1'b0;
						wd_timer  <= 13'(WATCHDOG_TICKS);
						drq       <= 1'b1;
						state     <= (state == ST_RD_DELAY) ? ST_RD_XFER : ST_WR_XFER;
					end
				end
				ST_RD_XFER, ST_WR_XFER: begin
					if (bark || (byte_seen && drq)) begin
						drq <= 1'b0;
						if (bark)
							lost_data <= 1'b1; // byte skipped
						if (!last_byte) begin
							byte_addr <= byte_addr + 1'b1;
							data_len  <= data_len - 1'b1;
							state     <= (state == ST_RD_XFER) ? ST_RD_ARM : ST_WR_ARM;
						end else if (state == ST_WR_XFER) begin
							state <= ST_FLUSH_CHK;
						end else if (multi) begin
							sector <= sector + 1'b1;
							timer  <= 12'(SEEK_DELAY);
							state  <= ST_SEEK;
						end else begin
							state <= ST_END;
						end
					end
				end
				ST_FLUSH_CHK: begin
					if (!ready) begin
						wr_fault <= 1'b1;
						state    <= ST_END;
					end else begin
						state <= ST_FLUSH_REQ;
					end
				end
				ST_FLUSH_REQ: begin
					blk_start <= 1'b1;
					blk_write <= 1'b1;
					state     <= ST_FLUSH_WAIT;
				end
				ST_FLUSH_WAIT: begin
					if (blk_done) begin
						if (multi) begin
							sector <= sector + 1'b1;
							timer  <= 12'(SEEK_DELAY);
							state  <= ST_SEEK;
						end else begin
							state <= ST_END;
						end
					end
				end
				ST_ABORT: begin
					seek_err  <= 1'b0;
					lost_data <= 1'b0;
					wr_fault  <= 1'b0;
					state     <= ST_END;
				end
				ST_BUSY_WAIT: begin
					timer <= 12'(BUSY_TICKS);
					state <= ST_BUSY_DELAY;
				end
				ST_BUSY_DELAY: if (timer != '0) timer <= timer - 1'b1; else state <= ST_END;
				ST_END: begin
					drq       <= 1'b0;
					busy      <= 1'b0;
					xfer_read <= 1'b0;
					intrq     <= 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase

			// ====================
			// register writes
			if (wr_start) begin
				case (bus_addr)
					A_COMMAND: begin
						intrq <= 1'b0;
						if (state == ST_IDLE || op == OP_FORCE_INT) begin
							cmd_mode <= din[7];
							wpe      <= ~din[7];
							case (op)
								OP_RESTORE: begin
									head_loaded <= din[3];
									head_track  <= '0;
									track_reg   <= '0;
									busy        <= 1'b1;
									state       <= ST_BUSY_WAIT;
								end
								OP_SEEK: begin
									head_loaded <= din[3];
									head_track  <= data_reg; // target track sits in data reg
									track_reg   <= data_reg;
									busy        <= 1'b1;
									state       <= ST_BUSY_WAIT;
								end
								OP_STEP, OP_STEP_U, OP_STEP_IN, OP_STEP_IN_U,
								OP_STEP_OUT, OP_STEP_OUT_U: begin
									if (din[6])
										step_dir <= din[5]; // remembered for plain step
									head_track  <= next_track;
									if (din[4])
										track_reg <= next_track;
									head_loaded <= din[3];
									busy        <= 1'b1;
									state       <= ST_BUSY_WAIT;
								end
								OP_READ, OP_READ_M, OP_WRITE, OP_WRITE_M: begin
									busy      <= 1'b1;
									seek_err  <= 1'b0;
									lost_data <= 1'b0;
									wr_fault  <= 1'b0;
									multi     <= din[4];
									xfer_read <= ~din[5];
									wpe       <= din[5];
									timer     <= 12'(SEEK_DELAY);
									state     <= ST_SEEK;
									if (wp && din[5]) begin
										wr_fault <= 1'b1;
										state    <= ST_BUSY_WAIT;
									end
								end
								OP_FORCE_INT: begin
									cmd_mode <= 1'b0;
									if (state != ST_IDLE) begin
										state <= ST_ABORT;
									end else begin
										seek_err  <= 1'b0;
										lost_data <= 1'b0;
										wr_fault  <= 1'b0;
										drq       <= 1'b0;
										busy      <= 1'b0;
									end
								end
								OP_READ_ADDR, OP_READ_TRACK, OP_WRITE_TRACK: ; // accepted, no action
							endcase
						end
					end
					A_TRACK:  if (!busy) track_reg <= din;
					A_SECTOR: if (!busy) sector <= din;
					A_DATA:   data_reg <= din;
				endcase
			end
		end
	end

endmodule

// ==== design/fdc_top.sv ====
module wd1793_fdc import fdc_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ce,        // cpu rate enable
	input  logic                  io_en,
	input  logic                  rd,
	input  logic                  wr,
	input  logic [1:0]            addr,
	input  logic [7:0]            din,
	input  logic                  wp,
	input  logic [2:0]            size_code,
	input  logic                  layout,    // 1 = side-track-sector image
	input  logic                  side,
	input  logic                  ready,
	input  logic                  img_mounted,
	input  logic [OFFSET_W-1:0]   img_size,
	input  logic                  sd_ack,
	input  logic [BLK_ADDR_W-1:0] sd_buff_addr,
	input  logic [7:0]            sd_buff_dout,
	input  logic                  sd_buff_wr,
	output logic [7:0]            dout,
	output logic                  drq,
	output logic                  intrq,
	output logic                  busy,
	output logic [31:0]           sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic [7:0]            sd_buff_din
);

	logic                  wr_start;
	logic [1:0]            bus_addr;
	logic                  rd_end_status;
	logic                  rd_end_data;
	logic                  wr_end_data;
	logic [TRACK_W-1:0]    head_track;
	logic [SECTOR_W-1:0]   sector;
	logic [TRACK_W-1:0]    track_reg;
	logic [7:0]            data_reg;
	logic [7:0]            status;
	logic                  xfer_read;
	logic [BUF_ADDR_W-1:0] byte_addr;
	logic                  buf_we;
	logic [7:0]            buf_q;
	logic                  blk_start;
	logic                  blk_write;
	logic                  blk_done;
	logic [BLK_IDX_W-1:0]  blk_count;
	logic [BLK_IDX_W-1:0]  sd_block;
	logic [OFFSET_W-1:0]   img_offset;
	logic [7:0]            spt;
	logic [1:0]            sector_code;

	cpu_bus_sync i_bus (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ce            (ce),
		.io_en         (io_en),
		.rd            (rd),
		.wr            (wr),
		.addr          (addr),
		.wr_start      (wr_start),
		.bus_addr      (bus_addr),
		.rd_end_status (rd_end_status),
		.rd_end_data   (rd_end_data),
		.wr_end_data   (wr_end_data)
	);

	fdc_controller i_ctrl (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ce            (ce),
		.din           (din),
		.wr_start      (wr_start),
		.bus_addr      (bus_addr),
		.rd_end_status (rd_end_status),
		.rd_end_data   (rd_end_data),
		.wr_end_data   (wr_end_data),
		.wp            (wp),
		.ready         (ready),
		.spt           (spt),
		.sector_code   (sector_code),
		.img_offset    (img_offset),
		.blk_done      (blk_done),
		.head_track    (head_track),
		.sector        (sector),
		.track_reg     (track_reg),
		.data_reg      (data_reg),
		.status        (status),
		.drq           (drq),
		.busy          (busy),
		.intrq         (intrq),
		.xfer_read     (xfer_read),
		.byte_addr     (byte_addr),
		.buf_we        (buf_we),
		.blk_start     (blk_start),
		.blk_write     (blk_write)
	);

	disk_geometry i_geom (
		.clk_sys     (clk_sys),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.layout      (layout),
		.size_code   (size_code),
		.side        (side),
		.head_track  (head_track),
		.sector      (sector),
		.img_offset  (img_offset),
		.spt         (spt),
		.sector_code (sector_code),
		.blk_count   (blk_count)
	);

	sd_block_xfer i_xfer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ce         (ce),
		.blk_start  (blk_start),
		.blk_write  (blk_write),
		.blk_count  (blk_count),
		.img_offset (img_offset),
		.sd_ack     (sd_ack),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_block   (sd_block),
		.sd_lba     (sd_lba),
		.blk_done   (blk_done)
	);

	sector_buffer i_buf (
		.clk_sys (clk_sys),
		.addr_a  ({sd_block, sd_buff_addr}),
		.data_a  (sd_buff_dout),
		.we_a    (sd_buff_wr & sd_ack),
		.q_a     (sd_buff_din),
		.addr_b  (byte_addr),
		.data_b  (din),
		.we_b    (buf_we),
		.q_b     (buf_q)
	);

	// cpu read mux
	always_comb begin
		case (addr)
			A_STATUS: dout = status;
			A_TRACK:  dout = track_reg;
			A_SECTOR: dout = sector;
			A_DATA:   dout = xfer_read ? buf_q : data_reg; // buffer byte while reading
		endcase
	end

endmodule

// ==== tb/sd_image_model.svh ====
	// ====================
	// sd card model holding one 64 KiB disk image
	localparam int IMG_BYTES = 65536;

	logic [7:0] image [0:IMG_BYTES-1];
	int         sd_wr_count; // write requests served

	// random image contents, called once the seed is set
	task automatic fill_image();
		int a;
		for (a = 0; a < IMG_BYTES; a++)
			image[a] = 8'($urandom);
	endtask

	// one 512 byte block per request, ack after a short delay
	initial begin
		int base;
		int k;
		bit to_card;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		sd_wr_count  = 0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				base    = int'(sd_lba) * 512;
				to_card = sd_wr;
				if (to_card)
					sd_wr_count++;
				repeat (3) @(posedge clk_sys);
				#2 sd_ack = 1'b1;
				if (to_card) begin
					// buffer read port is registered, data shows one clock after the address
					sd_buff_addr = '0;
					for (k = 0; k < 512; k++) begin
						@(posedge clk_sys);
						#2;
						image[base + k] = sd_buff_din;
						sd_buff_addr    = 9'(k + 1);
					end
				end else begin
					for (k = 0; k < 512; k++) begin
						sd_buff_addr = 9'(k);
						sd_buff_dout = image[base + k];
						sd_buff_wr   = 1'b1;
						@(posedge clk_sys);
						#2;
					end
					sd_buff_wr = 1'b0;
				end
				sd_ack = 1'b0; // block finished
			end
		end
	end

// ==== tb/fdc_tb.sv ====
module fdc_tb import fdc_pkg::*; ();

	logic        clk_sys;
	logic        reset;
	logic        ce;
	logic        io_en;
	logic        rd;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic        wp;
	logic [2:0]  size_code;
	logic        layout;
	logic        side;
	logic        ready;
	logic        img_mounted;
	logic [19:0] img_size;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout;
	logic        sd_buff_wr;
	logic [7:0]  dout;
	logic        drq;
	logic        intrq;
	logic        busy;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic [7:0]  sd_buff_din;

	int         checks = 0;
	int         errors = 0;
	logic [7:0] got_q [$];     // bytes waiting for the compare process
	logic [7:0] exp_q [$];
	string      msg_q [$];
	logic [7:0] wr_bytes [0:1023];
	logic [7:0] blk_copy [0:511];

	`include "sd_image_model.svh"

	wd1793_fdc i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// reference model
	function automatic int spt_of(input int sc);
		case (sc)
			1:       return 16;
			2:       return 9;
			3:       return 5;
			4:       return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int code_of(input int sc);
		case (sc)
			1:       return 1;
			2:       return 2;
			3:       return 3;
			4:       return 2;
			default: return 0;
		endcase
	endfunction

	function automatic int sec_bytes(input int sc);
		return 128 << code_of(sc);
	endfunction

	function automatic int ref_offset(input int trk, input int sd, input int sct,
			input bit lay, input int sc);
		int idx;
		int half;
		idx  = (lay ? trk : trk * 2 + sd) * spt_of(sc) + sct - 1;
		half = (lay && sd != 0) ? IMG_BYTES / 2 : 0; // side 1 in the upper half
		return half + (idx << (7 + code_of(sc)));
	endfunction

	// byte compare against the reference values
	always @(negedge clk_sys) begin
		logic [7:0] got;
		logic [7:0] want;
		string      what;
		while (got_q.size() > 0) begin
			got  = got_q.pop_front();
			want = exp_q.pop_front();
			what = msg_q.pop_front();
			checks++;
			if (got !== want) begin
				errors++;
				$display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, want);
			end
		end
	end

	task automatic expect_byte(input logic [7:0] got, input logic [7:0] want, input string what);
		got_q.push_back(got);
		exp_q.push_back(want);
		msg_q.push_back(what);
	endtask

	task automatic check_true(input bit good, input string what);
		checks++;
		if (!good) begin
			errors++;
			$display("[FAIL] %0t: %s", $time, what);
		end
	endtask

	// ====================
	// cpu bus
	task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		#2;
		addr  = a;
		din   = d;
		wr    = 1'b1;
		io_en = 1'b1;
		repeat (4) @(posedge clk_sys);
		#2;
		wr    = 1'b0;
		io_en = 1'b0;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic read_reg(input logic [1:0] a, output logic [7:0] d);
		@(posedge clk_sys);
		#2;
		addr  = a;
		rd    = 1'b1;
		io_en = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1 d = dout;
		#1;
		rd    = 1'b0;
		io_en = 1'b0;
		@(posedge clk_sys); // read end seen here
		#2;
	endtask

	// sel 0 drq, 1 intrq, 2 either
	task automatic wait_for(input int sel, input logic level, input int limit, output bit ok);
		int   n;
		logic v;
		ok = 1'b0;
		for (n = 0; n < limit && !ok; n++) begin
			@(negedge clk_sys);
			case (sel)
				0:       v = drq;
				1:       v = intrq;
				default: v = drq | intrq;
			endcase
			if (v == level)
				ok = 1'b1;
		end
		if (!ok) begin
			errors++;
			$display("timeout at %0t: line %0d did not reach %0b within %0d cycles",
				$time, sel, level, limit);
		end
	endtask

	task automatic mount_image(input bit lay);
		layout      = lay;
		img_mounted = 1'b1;
		repeat (2) @(posedge clk_sys);
		#2 img_mounted = 1'b0; // geometry latches on this edge
		repeat (2) @(posedge clk_sys);
		#2;
	endtask

	// ====================
	// command sequences
	task automatic run_type1(input logic [7:0] cmd, input int exp_track, output logic [7:0] st);
		logic [7:0] trk_rd;
		bit         ok;
		write_reg(A_COMMAND, cmd);
		wait_for(1, 1'b1, 2 * BUSY_TICKS, ok);
		check_true(!busy, $sformatf("busy high after command %02h", cmd));
		read_reg(A_STATUS, st);
		read_reg(A_TRACK, trk_rd);
		check_true(trk_rd == 8'(exp_track),
			$sformatf("track reg %0d after command %02h, expected %0d", trk_rd, cmd, exp_track));
		check_true(st[2] == (exp_track == 0), $sformatf("track 0 bit in status %02h", st));
	endtask

	task automatic seek_track(input int trk, output logic [7:0] st);
		write_reg(A_DATA, 8'(trk)); // seek target
		run_type1(8'h10, trk, st);
	endtask

	task automatic read_sector(input int trk, input int sd, input int sct, input bit multi,
			output int cnt, output logic [7:0] st);
		logic [7:0] d;
		int         cur;
		int         idx;
		bit         ok;
		side = sd;
		seek_track(trk, st);
		write_reg(A_SECTOR, 8'(sct));
		write_reg(A_COMMAND, multi ? 8'h90 : 8'h80);
		cnt = 0;
		cur = sct;
		idx = 0;
		ok  = 1'b1;
		while (ok) begin
			wait_for(2, 1'b1, 20000, ok);
			if (ok && drq) begin
				read_reg(A_DATA, d);
				expect_byte(d, image[ref_offset(trk, sd, cur, layout, size_code) + idx],
					$sformatf("track %0d side %0d sector %0d byte %0d", trk, sd, cur, idx));
				cnt++;
				idx++;
				if (idx == sec_bytes(size_code)) begin
					idx = 0;
					cur++;
				end
				wait_for(0, 1'b0, 50, ok);
			end else begin
				ok = 1'b0; // intrq ends the command
			end
		end
		read_reg(A_STATUS, st);
	endtask

	task automatic write_sector(input int trk, input int sd, input int sct,
			output int cnt, output logic [7:0] st);
		bit ok;
		side = sd;
		seek_track(trk, st);
		write_reg(A_SECTOR, 8'(sct));
		write_reg(A_COMMAND, 8'hA0);
		cnt = 0;
		ok  = 1'b1;
		while (ok) begin
			wait_for(2, 1'b1, 20000, ok);
			if (ok && drq) begin
				write_reg(A_DATA, wr_bytes[cnt % 1024]);
				cnt++;
				wait_for(0, 1'b0, 50, ok);
			end else begin
				ok = 1'b0;
			end
		end
		read_reg(A_STATUS, st);
	endtask

	// ====================
	// tests
	initial begin
		logic [7:0] st;
		int         trk;
		int         sct;
		int         cnt;
		int         lay;
		int         sc;
		int         off;
		int         base;
		int         n;
		int         wr_before;
		bit         ok;
		void'($urandom(32'hd2f64144));
		fill_image();
		reset       = 1'b1;
		ce          = 1'b1;
		io_en       = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = '0;
		din         = '0;
		wp          = 1'b0;
		size_code   = '0;
		layout      = 1'b0;
		side        = 1'b0;
		ready       = 1'b0;
		img_mounted = 1'b0;
		img_size    = 20'(IMG_BYTES);
		repeat (2) @(posedge clk_sys);
		#2 reset = 1'b0;

		// state after reset
		@(negedge clk_sys);
		check_true(!drq && !intrq && !busy && !sd_rd && !sd_wr, "outputs not low after reset");
		read_reg(A_STATUS, st);
		check_true(st == 8'h80, $sformatf("status %02h with drive not ready", st));
		ready = 1'b1;
		read_reg(A_STATUS, st);
		check_true(st == 8'h00, $sformatf("status %02h with drive ready", st));

		// seek, step in with update, restore
		trk = $urandom_range(40, 1);
		seek_track(trk, st);
		run_type1(8'h50, trk + 1, st);
		run_type1(8'h00, 0, st);

		// single and multi sector reads, both image layouts
		for (lay = 0; lay < 2; lay++) begin
			mount_image(lay[0]);
			for (sc = 0; sc < 5; sc++) begin
				size_code = 3'(sc);
				sct = $urandom_range(spt_of(sc), 1);
				read_sector(1, sc % 2, sct, 1'b0, cnt, st);
				check_true(cnt == sec_bytes(sc), $sformatf("read gave %0d bytes", cnt));
				check_true(st == 8'h00, $sformatf("status %02h after read", st));
			end
			sc = lay ? 3 : 1;
			size_code = 3'(sc);
			read_sector(1, 0, spt_of(sc) - 1, 1'b1, cnt, st);
			check_true(cnt == 2 * sec_bytes(sc), $sformatf("multi read gave %0d bytes", cnt));
			check_true(st[4], "no record-not-found after the last sector");
		end

		// write then read back, 128 byte sector inside a block
		mount_image(1'b0);
		size_code = 3'd0;
		sct  = $urandom_range(26, 1);
		off  = ref_offset(1, 0, sct, 1'b0, 0);
		base = off - off % 512;
		for (n = 0; n < 512; n++)
			blk_copy[n] = image[base + n];
		for (n = 0; n < 128; n++)
			wr_bytes[n] = 8'($urandom);
		write_sector(1, 0, sct, cnt, st);
		check_true(cnt == 128, $sformatf("write took %0d bytes", cnt));
		check_true(st == 8'h00, $sformatf("status %02h after write", st));
		for (n = 0; n < 512; n++) begin
			if (base + n >= off && base + n < off + 128)
				expect_byte(image[base + n], wr_bytes[base + n - off],
					$sformatf("image byte %0d", base + n));
			else
				expect_byte(image[base + n], blk_copy[n],
					$sformatf("neighbor byte %0d", base + n));
		end
		read_sector(1, 0, sct, 1'b0, cnt, st);
		check_true(cnt == 128, $sformatf("read-back gave %0d bytes", cnt));

		// write protect
		wp        = 1'b1;
		wr_before = sd_wr_count;
		write_reg(A_SECTOR, 8'd1);
		write_reg(A_COMMAND, 8'hA0);
		wait_for(1, 1'b1, 2 * BUSY_TICKS, ok);
		read_reg(A_STATUS, st);
		check_true(st[6] && st[5] && !st[0], $sformatf("status %02h on protected write", st));
		check_true(sd_wr_count == wr_before, "sd write issued while protected");
		wp = 1'b0;

		// sector beyond the track
		size_code = 3'd2;
		write_reg(A_SECTOR, 8'd10);
		write_reg(A_COMMAND, 8'h80);
		wait_for(1, 1'b1, 4 * SEEK_DELAY, ok);
		read_reg(A_STATUS, st);
		check_true(st[4], $sformatf("status %02h for missing sector", st));

		// force interrupt in the middle of a read
		size_code = 3'd3;
		write_reg(A_SECTOR, 8'd1);
		write_reg(A_COMMAND, 8'h80);
		wait_for(0, 1'b1, 20000, ok);
		read_reg(A_DATA, st);
		write_reg(A_COMMAND, 8'hD0);
		wait_for(1, 1'b1, 100, ok);
		check_true(!busy && !drq, "busy or drq left high after force interrupt");
		read_reg(A_STATUS, st);

		// nobody reads the data register
		size_code = 3'd0;
		write_reg(A_SECTOR, 8'd2);
		write_reg(A_COMMAND, 8'h80);
		wait_for(1, 1'b1, 140 * (WATCHDOG_TICKS + 64), ok);
		read_reg(A_STATUS, st);
		check_true(st[2] && !st[0], $sformatf("status %02h after unserviced read", st));

		for (n = 0; n < 20 && got_q.size() > 0; n++)
			@(negedge clk_sys);
		if (got_q.size() > 0) begin
			errors++;
			$display("compare queue still holds %0d bytes at the end", got_q.size());
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// run limit
	initial begin
		repeat (3000000) @(posedge clk_sys);
		$display("run limit reached at %0t, stopping", $time);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tb
design/fdc_pkg.sv
design/sector_buffer.sv
design/disk_geometry.sv
design/cpu_bus_sync.sv
design/sd_block_xfer.sv
design/fdc_controller.sv
design/fdc_top.sv
tb/fdc_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := fdc_tb
RTL_TOP    := wd1793_fdc
FILELIST   := verilog.f
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
